// ==== src/isaPkg.sv ====
package isaPkg;

  localparam int dataWidth = 32;
  localparam int regAddrWidth = 5;
  localparam int memWords = 256;

  // Word index is taken from pc[9:2]
  localparam int wordLsb = 2;
  localparam int memIdxWidth = $clog2(memWords);

  // Instruction field positions
  localparam int opWidth = 6;
  localparam int opLsb = 26;
  localparam int rsLsb = 21;
  localparam int rtLsb = 16;
  localparam int rdLsb = 11;
  localparam int functLsb = 0;
  localparam int immWidth = 16;
  localparam int targetWidth = 26;

  typedef enum logic [opWidth-1:0] {
    rType = 6'h00,
    j     = 6'h02,
    beq   = 6'h04,
    bne   = 6'h05,
    addi  = 6'h08,
    lw    = 6'h23,
    sw    = 6'h2b
  } opcodeT;

  typedef enum logic [opWidth-1:0] {
    functAdd = 6'h20,
    functSub = 6'h22,
    functAnd = 6'h24,
    functOr  = 6'h25,
    functSlt = 6'h2a
  } functT;

endpackage

// ==== src/pipePkg.sv ====
package pipePkg;

  // Operation carried from decode to the execute ALU
  typedef enum logic [2:0] {
    aluAdd,
    aluSub,
    aluAnd,
    aluOr,
    aluSlt
  } aluOpT;

  // Source of an execute operand
  typedef enum logic [1:0] {
    fwdNone,
    fwdMem,
    fwdWb
  } fwdSelT;

endpackage

// ==== src/fetchStage.sv ====
`timescale 1ns/10ps

module fetchStage
  import isaPkg::*;
(
  input  logic                 clock,
  input  logic                 rstN,
  input  logic                 stall,
  input  logic                 redirect,
  input  logic [dataWidth-1:0] target,
  input  logic                 ifIdFlush,
  input  logic [dataWidth-1:0] instrIn,
  output logic [dataWidth-1:0] pc,
  output logic [dataWidth-1:0] instrId,
  output logic [dataWidth-1:0] pcPlus4Id
);

  logic [dataWidth-1:0] pcPlus4;

  assign pcPlus4 = pc + dataWidth'(4);

  // Stall wins over a redirect
  // The branch resolves again next cycle
  always_ff @(posedge clock or negedge rstN) begin
    if (!rstN) begin
      pc <= '0;
    end else if (!stall) begin
      pc <= redirect ? target : pcPlus4;
    end
  end

  // All-zero word decodes as a no-op
  always_ff @(posedge clock or negedge rstN) begin
    if (!rstN) begin
      instrId <= '0;
    end else if (!stall) begin
      instrId <= ifIdFlush ? '0 : instrIn;
    end
  end

  always_ff @(posedge clock) begin
    if (!stall) begin
      pcPlus4Id <= pcPlus4;
    end
  end

endmodule

// ==== src/decodeStage.sv ====
`timescale 1ns/10ps

module decodeStage
  import isaPkg::*;
  import pipePkg::*;
(
  input  logic                    clock,
  input  logic                    rstN,
  input  logic [dataWidth-1:0]    instrId,
  input  logic [dataWidth-1:0]    pcPlus4Id,
  input  logic                    idExFlush,
  input  logic                    wbEn,
  input  logic [regAddrWidth-1:0] wbReg,
  input  logic [dataWidth-1:0]    wbData,
  input  logic [dataWidth-1:0]    aluResultMem,
  input  logic [regAddrWidth-1:0] destMem,
  input  logic                    regWriteMem,
  output logic                    redirect,
  output logic [dataWidth-1:0]    target,
  output logic [regAddrWidth-1:0] rsId,
  output logic [regAddrWidth-1:0] rtId,
  output logic                    usesRs,
  output logic                    usesRt,
  output logic                    isBranch,
  output logic [dataWidth-1:0]    rsDataEx,
  output logic [dataWidth-1:0]    rtDataEx,
  output logic [dataWidth-1:0]    immEx,
  output logic [regAddrWidth-1:0] rsEx,
  output logic [regAddrWidth-1:0] rtEx,
  output logic [regAddrWidth-1:0] rdEx,
  output aluOpT                   aluOpEx,
  output logic                    aluSrcEx,
  output logic                    regDstEx,
  output logic                    memReadEx,
  output logic                    memWriteEx,
  output logic                    memToRegEx,
  output logic                    regWriteEx
);

  opcodeT                  opcode;
  functT                   funct;
  logic [regAddrWidth-1:0] rdId;
  logic [dataWidth-1:0]    immId;
  logic [dataWidth-1:0]    rsData;
  logic [dataWidth-1:0]    rtData;
  logic [dataWidth-1:0]    regs [2**regAddrWidth];
  aluOpT                   aluOp;
  logic                    aluSrc;
  logic                    regDst;
  logic                    memRead;
  logic                    memWrite;
  logic                    memToReg;
  logic                    regWrite;
  logic                    isJump;

  assign opcode = opcodeT'(instrId[opLsb +: opWidth]);
  assign funct  = functT'(instrId[functLsb +: opWidth]);
  assign rsId   = instrId[rsLsb +: regAddrWidth];
  assign rtId   = instrId[rtLsb +: regAddrWidth];
  assign rdId   = instrId[rdLsb +: regAddrWidth];
  assign immId  = {{(dataWidth-immWidth){instrId[immWidth-1]}}, instrId[immWidth-1:0]};

  always_comb begin
    aluOp    = aluAdd;
    aluSrc   = 1'b0;
    regDst   = 1'b0;
    memRead  = 1'b0;
    memWrite = 1'b0;
    memToReg = 1'b0;
    regWrite = 1'b0;
    usesRs   = 1'b0;
    usesRt   = 1'b0;
    isBranch = 1'b0;
    isJump   = 1'b0;
    case (opcode)
      rType: begin
        regDst   = 1'b1;
        regWrite = 1'b1;
        usesRs   = 1'b1;
        usesRt   = 1'b1;
        case (funct)
          functAdd: aluOp = aluAdd;
          functSub: aluOp = aluSub;
          functAnd: aluOp = aluAnd;
          functOr:  aluOp = aluOr;
          functSlt: aluOp = aluSlt;
          // Unknown funct including the flushed no-op
          default:  regWrite = 1'b0;
        endcase
      end
      addi: begin
        aluSrc   = 1'b1;
        regWrite = 1'b1;
        usesRs   = 1'b1;
      end
      lw: begin
        aluSrc   = 1'b1;
        memRead  = 1'b1;
        memToReg = 1'b1;
        regWrite = 1'b1;
        usesRs   = 1'b1;
      end
      sw: begin
        aluSrc   = 1'b1;
        memWrite = 1'b1;
        usesRs   = 1'b1;
        usesRt   = 1'b1;
      end
      beq, bne: begin
        isBranch = 1'b1;
        usesRs   = 1'b1;
        usesRt   = 1'b1;
      end
      j:       isJump = 1'b1;
      default: isJump = 1'b0;
    endcase
  end

  // Register zero, then ALU result in memory, then writeback
  // A load address picked up here is replaced by execute forwarding
  function automatic logic [dataWidth-1:0] readReg(input logic [regAddrWidth-1:0] addr);
    if (addr == '0) begin
      return '0;
    end else if (regWriteMem && destMem == addr) begin
      return aluResultMem;
    end else if (wbEn && wbReg == addr) begin
      return wbData;
    end
    return regs[addr];
  endfunction

  always_comb begin
    rsData = readReg(rsId);
    rtData = readReg(rtId);
  end

  always_ff @(posedge clock) begin
    if (wbEn) begin
      regs[wbReg] <= wbData;
    end
  end

  // bne inverts the equality test
  assign redirect = isJump || (isBranch && ((rsData == rtData) != (opcode == bne)));
  assign target   = isJump ?
      {pcPlus4Id[dataWidth-1 -: dataWidth-targetWidth-wordLsb],
       instrId[targetWidth-1:0], {wordLsb{1'b0}}} :
      pcPlus4Id + (immId << wordLsb);

  always_ff @(posedge clock or negedge rstN) begin
    if (!rstN) begin
      aluOpEx    <= aluAdd;
      aluSrcEx   <= 1'b0;
      regDstEx   <= 1'b0;
      memReadEx  <= 1'b0;
      memWriteEx <= 1'b0;
      memToRegEx <= 1'b0;
      regWriteEx <= 1'b0;
    end else if (idExFlush) begin
      aluOpEx    <= aluAdd;
      aluSrcEx   <= 1'b0;
      regDstEx   <= 1'b0;
      memReadEx  <= 1'b0;
      memWriteEx <= 1'b0;
      memToRegEx <= 1'b0;
      regWriteEx <= 1'b0;
    end else begin
      aluOpEx    <= aluOp;
      aluSrcEx   <= aluSrc;
      regDstEx   <= regDst;
      memReadEx  <= memRead;
      memWriteEx <= memWrite;
      memToRegEx <= memToReg;
      regWriteEx <= regWrite;
    end
  end

  always_ff @(posedge clock) begin
    rsDataEx <= rsData;
    rtDataEx <= rtData;
    immEx    <= immId;
    rsEx     <= rsId;
    rtEx     <= rtId;
    rdEx     <= rdId;
  end

endmodule

// ==== src/hazardUnit.sv ====
`timescale 1ns/10ps

module hazardUnit
  import isaPkg::*;
(
  input  logic [regAddrWidth-1:0] rsId,
  input  logic [regAddrWidth-1:0] rtId,
  input  logic                    usesRs,
  input  logic                    usesRt,
  input  logic                    isBranch,
  input  logic [regAddrWidth-1:0] rtEx,
  input  logic                    memReadEx,
  input  logic [regAddrWidth-1:0] destEx,
  input  logic                    regWriteEx,
  input  logic [regAddrWidth-1:0] destMem,
  input  logic                    memReadMem,
  output logic                    stall,
  output logic                    idExFlush
);

  logic loadUse;
  logic branchOnEx;
  logic branchOnMem;

  // True when decode reads a non-zero register about to be written
  function automatic logic readsReg(input logic [regAddrWidth-1:0] dest);
    return (dest != '0) && ((usesRs && rsId == dest) || (usesRt && rtId == dest));
  endfunction

  always_comb begin
    loadUse     = memReadEx && readsReg(rtEx);
    branchOnEx  = isBranch && regWriteEx && readsReg(destEx);
    branchOnMem = isBranch && memReadMem && readsReg(destMem);
  end

  // Decode holds and a bubble goes into execute
  assign stall     = loadUse || branchOnEx || branchOnMem;
  assign idExFlush = stall;

endmodule

// ==== src/executeStage.sv ====
`timescale 1ns/10ps

module executeStage
  import isaPkg::*;
  import pipePkg::*;
(
  input  logic                    clock,
  input  logic                    rstN,
  input  logic [dataWidth-1:0]    rsDataEx,
  input  logic [dataWidth-1:0]    rtDataEx,
  input  logic [dataWidth-1:0]    immEx,
  input  logic [regAddrWidth-1:0] rsEx,
  input  logic [regAddrWidth-1:0] rtEx,
  input  logic [regAddrWidth-1:0] rdEx,
  input  aluOpT                   aluOpEx,
  input  logic                    aluSrcEx,
  input  logic                    regDstEx,
  input  logic                    memReadEx,
  input  logic                    memWriteEx,
  input  logic                    memToRegEx,
  input  logic                    regWriteEx,
  input  logic                    wbEn,
  input  logic [regAddrWidth-1:0] wbReg,
  input  logic [dataWidth-1:0]    wbData,
  output logic [regAddrWidth-1:0] destEx,
  output logic [dataWidth-1:0]    aluResultMem,
  output logic [dataWidth-1:0]    storeDataMem,
  output logic [regAddrWidth-1:0] destMem,
  output logic                    memReadMem,
  output logic                    memWriteMem,
  output logic                    memToRegMem,
  output logic                    regWriteMem
);

  fwdSelT               fwdA;
  fwdSelT               fwdB;
  logic [dataWidth-1:0] opA;
  logic [dataWidth-1:0] rtFwd;
  logic [dataWidth-1:0] opB;
  logic [dataWidth-1:0] aluResult;

  // Memory stage is younger and wins over writeback
  function automatic fwdSelT selectFwd(input logic [regAddrWidth-1:0] src);
    if (src == '0) begin
      return fwdNone;
    end else if (regWriteMem && destMem == src) begin
      return fwdMem;
    end else if (wbEn && wbReg == src) begin
      return fwdWb;
    end
    return fwdNone;
  endfunction

  always_comb begin
    fwdA = selectFwd(rsEx);
    fwdB = selectFwd(rtEx);
    case (fwdA)
      fwdMem:  opA = aluResultMem;
      fwdWb:   opA = wbData;
      default: opA = rsDataEx;
    endcase
    case (fwdB)
      fwdMem:  rtFwd = aluResultMem;
      fwdWb:   rtFwd = wbData;
      default: rtFwd = rtDataEx;
    endcase
    opB = aluSrcEx ? immEx : rtFwd;
  end

  always_comb begin
    case (aluOpEx)
      aluSub:  aluResult = opA - opB;
      aluAnd:  aluResult = opA & opB;
      aluOr:   aluResult = opA | opB;
      aluSlt:  aluResult = {{(dataWidth-1){1'b0}}, ($signed(opA) < $signed(opB))};
      default: aluResult = opA + opB;
    endcase
  end

  // R-type writes rd, immediate forms write rt
  assign destEx = regDstEx ? rdEx : rtEx;

  always_ff @(posedge clock or negedge rstN) begin
    if (!rstN) begin
      memReadMem  <= 1'b0;
      memWriteMem <= 1'b0;
      memToRegMem <= 1'b0;
      regWriteMem <= 1'b0;
    end else begin
      memReadMem  <= memReadEx;
      memWriteMem <= memWriteEx;
      memToRegMem <= memToRegEx;
      regWriteMem <= regWriteEx;
    end
  end

  always_ff @(posedge clock) begin
    aluResultMem <= aluResult;
    storeDataMem <= rtFwd;
    destMem      <= destEx;
  end

endmodule

// ==== src/unifiedMemory.sv ====
`timescale 1ns/10ps

module unifiedMemory
  import isaPkg::*;
(
  input  logic                 clock,
  input  logic [dataWidth-1:0] pc,
  input  logic [dataWidth-1:0] dataAddr,
  input  logic                 dataWe,
  input  logic [dataWidth-1:0] dataWdata,
  input  logic                 progWe,
  input  logic [dataWidth-1:0] progAddr,
  input  logic [dataWidth-1:0] progData,
  output logic [dataWidth-1:0] instr,
  output logic [dataWidth-1:0] dataRdata
);

  logic [dataWidth-1:0] mem [memWords];

  // Both reads are asynchronous on byte addresses
  assign instr     = mem[pc[wordLsb +: memIdxWidth]];
  assign dataRdata = mem[dataAddr[wordLsb +: memIdxWidth]];

  // Program load takes the port over
  always_ff @(posedge clock) begin
    if (progWe) begin
      mem[progAddr[wordLsb +: memIdxWidth]] <= progData;
    end else if (dataWe) begin
      mem[dataAddr[wordLsb +: memIdxWidth]] <= dataWdata;
    end
  end

endmodule

// ==== src/memWriteback.sv ====
`timescale 1ns/10ps

module memWriteback
  import isaPkg::*;
(
  input  logic                    clock,
  input  logic                    rstN,
  input  logic [dataWidth-1:0]    aluResultMem,
  input  logic [dataWidth-1:0]    dataRdata,
  input  logic [regAddrWidth-1:0] destMem,
  input  logic                    memToRegMem,
  input  logic                    regWriteMem,
  output logic                    wbEn,
  output logic [regAddrWidth-1:0] wbReg,
  output logic [dataWidth-1:0]    wbData
);

  // Writes to register zero are dropped here
  always_ff @(posedge clock or negedge rstN) begin
    if (!rstN) begin
      wbEn <= 1'b0;
    end else begin
      wbEn <= regWriteMem && (destMem != '0);
    end
  end

  always_ff @(posedge clock) begin
    wbReg  <= destMem;
    wbData <= memToRegMem ? dataRdata : aluResultMem;
  end

endmodule

// ==== src/cpu.sv ====
`timescale 1ns/10ps

module cpu
  import isaPkg::*;
  import pipePkg::*;
(
  input  logic                    clock,
  input  logic                    rstN,
  input  logic                    progWe,
  input  logic [dataWidth-1:0]    progAddr,
  input  logic [dataWidth-1:0]    progData,
  output logic                    wbEn,
  output logic [regAddrWidth-1:0] wbReg,
  output logic [dataWidth-1:0]    wbData
);

  // Fetch and decode
  logic [dataWidth-1:0]    pc;
  logic [dataWidth-1:0]    instr;
  logic [dataWidth-1:0]    instrId;
  logic [dataWidth-1:0]    pcPlus4Id;
  logic                    redirect;
  logic [dataWidth-1:0]    target;
  logic [regAddrWidth-1:0] rsId;
  logic [regAddrWidth-1:0] rtId;
  logic                    usesRs;
  logic                    usesRt;
  logic                    isBranch;
  logic                    stall;
  logic                    idExFlush;

  // ID/EX
  logic [dataWidth-1:0]    rsDataEx;
  logic [dataWidth-1:0]    rtDataEx;
  logic [dataWidth-1:0]    immEx;
  logic [regAddrWidth-1:0] rsEx;
  logic [regAddrWidth-1:0] rtEx;
  logic [regAddrWidth-1:0] rdEx;
  aluOpT                   aluOpEx;
  logic                    aluSrcEx;
  logic                    regDstEx;
  logic                    memReadEx;
  logic                    memWriteEx;
  logic                    memToRegEx;
  logic                    regWriteEx;
  logic [regAddrWidth-1:0] destEx;

  // EX/MEM
  logic [dataWidth-1:0]    aluResultMem;
  logic [dataWidth-1:0]    storeDataMem;
  logic [regAddrWidth-1:0] destMem;
  logic                    memReadMem;
  logic                    memWriteMem;
  logic                    memToRegMem;
  logic                    regWriteMem;
  logic [dataWidth-1:0]    dataRdata;

  // A taken branch or jump also flushes IF/ID
  fetchStage u_fetch (
    .clock(clock), .rstN(rstN), .stall(stall),
    .redirect(redirect), .target(target), .ifIdFlush(redirect),
    .instrIn(instr), .pc(pc), .instrId(instrId), .pcPlus4Id(pcPlus4Id)
  );

  decodeStage u_decode (
    .clock(clock), .rstN(rstN), .instrId(instrId), .pcPlus4Id(pcPlus4Id),
    .idExFlush(idExFlush), .wbEn(wbEn), .wbReg(wbReg), .wbData(wbData),
    .aluResultMem(aluResultMem), .destMem(destMem), .regWriteMem(regWriteMem),
    .redirect(redirect), .target(target), .rsId(rsId), .rtId(rtId),
    .usesRs(usesRs), .usesRt(usesRt), .isBranch(isBranch),
    .rsDataEx(rsDataEx), .rtDataEx(rtDataEx), .immEx(immEx),
    .rsEx(rsEx), .rtEx(rtEx), .rdEx(rdEx),
    .aluOpEx(aluOpEx), .aluSrcEx(aluSrcEx), .regDstEx(regDstEx),
    .memReadEx(memReadEx), .memWriteEx(memWriteEx),
    .memToRegEx(memToRegEx), .regWriteEx(regWriteEx)
  );

  hazardUnit u_hazard (
    .rsId(rsId), .rtId(rtId), .usesRs(usesRs), .usesRt(usesRt),
    .isBranch(isBranch), .rtEx(rtEx), .memReadEx(memReadEx),
    .destEx(destEx), .regWriteEx(regWriteEx),
    .destMem(destMem), .memReadMem(memReadMem),
    .stall(stall), .idExFlush(idExFlush)
  );

  executeStage u_execute (
    .clock(clock), .rstN(rstN),
    .rsDataEx(rsDataEx), .rtDataEx(rtDataEx), .immEx(immEx),
    .rsEx(rsEx), .rtEx(rtEx), .rdEx(rdEx),
    .aluOpEx(aluOpEx), .aluSrcEx(aluSrcEx), .regDstEx(regDstEx),
    .memReadEx(memReadEx), .memWriteEx(memWriteEx),
    .memToRegEx(memToRegEx), .regWriteEx(regWriteEx),
    .wbEn(wbEn), .wbReg(wbReg), .wbData(wbData),
    .destEx(destEx), .aluResultMem(aluResultMem), .storeDataMem(storeDataMem),
    .destMem(destMem), .memReadMem(memReadMem), .memWriteMem(memWriteMem),
    .memToRegMem(memToRegMem), .regWriteMem(regWriteMem)
  );

  // ALU result doubles as the data address
  unifiedMemory u_memory (
    .clock(clock), .pc(pc),
    .dataAddr(aluResultMem), .dataWe(memWriteMem), .dataWdata(storeDataMem),
    .progWe(progWe), .progAddr(progAddr), .progData(progData),
    .instr(instr), .dataRdata(dataRdata)
  );

  memWriteback u_writeback (
    .clock(clock), .rstN(rstN),
    .aluResultMem(aluResultMem), .dataRdata(dataRdata), .destMem(destMem),
    .memToRegMem(memToRegMem), .regWriteMem(regWriteMem),
    .wbEn(wbEn), .wbReg(wbReg), .wbData(wbData)
  );

endmodule

// ==== testbench/cpu_props.sv ====
`timescale 1ns/10ps

module cpu_props
  import isaPkg::*;
(
  input logic                    clock,
  input logic                    rstN,
  input logic                    wbEn,
  input logic [regAddrWidth-1:0] wbReg,
  input logic                    stall,
  input logic                    regWriteEx,
  input logic                    memReadEx,
  input logic                    memWriteEx,
  input logic                    memWriteMem,
  input logic                    progWe
);

  noWbInReset: assert property (@(posedge clock) !rstN |-> !wbEn)
    else $error("Writeback enable seen while reset is active");

  noWbToZero: assert property (@(posedge clock) wbEn |-> (wbReg != '0))
    else $error("Writeback enable seen for register zero");

  // Every stalled cycle puts a bubble into execute
  stallFlushes: assert property (@(posedge clock) disable iff (!rstN)
      stall |=> !(regWriteEx || memReadEx || memWriteEx))
    else $error("Stall did not leave a bubble in execute");

  noStoreDuringLoad: assert property (@(posedge clock) !(memWriteMem && progWe))
    else $error("Data store and program load in the same cycle");

endmodule

bind cpu cpu_props u_props (
  .clock(clock), .rstN(rstN), .wbEn(wbEn), .wbReg(wbReg),
  .stall(stall), .regWriteEx(regWriteEx), .memReadEx(memReadEx),
  .memWriteEx(memWriteEx), .memWriteMem(memWriteMem), .progWe(progWe)
);

// ==== testbench/cpuTb.sv ====
`timescale 1ns/10ps

module cpuTb
  import isaPkg::*;
();

  localparam int period = 40;
  localparam int resetCycles = 8;
  localparam int numTests = 5;
  // Static lengths of the five programs
  // All branches go forward
  localparam int totalInstr = 11 + 14 + 20 + 10 + 45;
  localparam int perTestCycles = memWords + resetCycles + 40;
  localparam int watchdogCycles = totalInstr * 3 + numTests * perTestCycles;

  logic                    clock;
  logic                    rstN;
  logic                    progWe;
  logic [dataWidth-1:0]    progAddr;
  logic [dataWidth-1:0]    progData;
  logic                    wbEn;
  logic [regAddrWidth-1:0] wbReg;
  logic [dataWidth-1:0]    wbData;

  logic [31:0] prog [$];
  logic [31:0] modelMem [memWords];
  logic [31:0] expReg [$];
  logic [31:0] expData [$];
  integer      seed = 60942;
  int          checkCount = 0;
  int          valueErrors = 0;
  int          otherErrors = 0;

  cpu i_cpu (
    .clock(clock), .rstN(rstN), .progWe(progWe), .progAddr(progAddr),
    .progData(progData), .wbEn(wbEn), .wbReg(wbReg), .wbData(wbData)
  );

  initial begin
    clock = 1'b0;
    forever #(period / 2) clock = ~clock;
  end

  initial begin
    #(watchdogCycles * period);
    $display("Timeout: the writebacks did not finish in %0d cycles", watchdogCycles);
    $display("sim failed");
    $finish;
  end

  function automatic logic [31:0] rEnc(input functT fn, input int rd, input int rs, input int rt);
    return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
  endfunction

  function automatic logic [31:0] iEnc(input opcodeT op, input int rt, input int rs,
                                       input int imm);
    return {op, 5'(rs), 5'(rt), 16'(imm)};
  endfunction

  function automatic logic [31:0] jEnc(input int idx);
    return {j, 26'(idx)};
  endfunction

  // Spread every address bit over the word
  function automatic logic [31:0] fillWord(input int idx);
    return (32'(idx) * 32'h9E3779B1) ^ 32'hA5A5A5A5;
  endfunction

  task automatic addSelfJump();
    prog.push_back(jEnc(prog.size()));
  endtask

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    checkCount++;
    if (expected !== actual) begin
      $display("FAIL %s expected 0x%08h actual 0x%08h", name, expected, actual);
      valueErrors++;
    end
  endtask

  // ISA reference model that runs until the final self-jump
  task automatic runModel();
    logic [31:0] regs [32];
    logic [31:0] pc;
    logic [31:0] instr;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    logic [31:0] addr;
    logic [31:0] nextPc;
    logic [31:0] jumpTarget;
    logic [31:0] result;
    logic [4:0]  dest;
    logic        writes;
    logic        done;
    int          steps;
    for (int k = 0; k < 32; k++) begin
      regs[k] = '0;
    end
    expReg.delete();
    expData.delete();
    pc = '0;
    done = 1'b0;
    steps = 0;
    while (!done && steps < 1000) begin
      instr = modelMem[pc[9:2]];
      a = regs[instr[25:21]];
      b = regs[instr[20:16]];
      imm = {{16{instr[15]}}, instr[15:0]};
      nextPc = pc + 32'd4;
      dest = instr[20:16];
      writes = 1'b0;
      result = '0;
      case (opcodeT'(instr[31:26]))
        rType: begin
          dest = instr[15:11];
          writes = 1'b1;
          case (functT'(instr[5:0]))
            functAdd: result = a + b;
            functSub: result = a - b;
            functAnd: result = a & b;
            functOr:  result = a | b;
            functSlt: result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default:  writes = 1'b0;
          endcase
        end
        addi: begin
          writes = 1'b1;
          result = a + imm;
        end
        lw: begin
          writes = 1'b1;
          addr = a + imm;
          result = modelMem[addr[9:2]];
        end
        sw: begin
          addr = a + imm;
          modelMem[addr[9:2]] = b;
        end
        beq: if (a == b) nextPc = nextPc + (imm << 2);
        bne: if (a != b) nextPc = nextPc + (imm << 2);
        j: begin
          jumpTarget = {nextPc[31:28], instr[25:0], 2'b00};
          done = (jumpTarget == pc);
          nextPc = jumpTarget;
        end
        default: writes = 1'b0;
      endcase
      // r0 never shows up as a writeback
      if (writes && dest != 5'd0) begin
        regs[dest] = result;
        expReg.push_back(32'(dest));
        expData.push_back(result);
      end
      pc = nextPc;
      steps++;
    end
    if (!done) begin
      $display("Reference model never reached the final self-jump");
      otherErrors++;
    end
  endtask

  // Load under reset, then compare every writeback in order
  task automatic runProgram(input string testName);
    logic [31:0] word;
    int          idx;
    $display("Running %s, %0d instructions", testName, prog.size());
    @(negedge clock);
    rstN = 1'b0;
    for (int i = 0; i < memWords; i++) begin
      word = (i < prog.size()) ? prog[i] : fillWord(i);
      modelMem[i] = word;
      @(negedge clock);
      progWe = 1'b1;
      progAddr = 32'(i * 4);
      progData = word;
    end
    @(negedge clock);
    progWe = 1'b0;
    repeat (resetCycles) @(negedge clock);
    runModel();
    rstN = 1'b1;
    idx = 0;
    while (idx < expReg.size()) begin
      @(negedge clock);
      if (wbEn) begin
        checkValue("wbReg", expReg[idx], 32'(wbReg));
        checkValue("wbData", expData[idx], wbData);
        idx++;
      end
    end
    for (int i = 0; i < 20; i++) begin
      @(negedge clock);
      if (wbEn) begin
        $display("%s: unexpected extra write of register %0d after the last one",
                 testName, wbReg);
        otherErrors++;
      end
    end
  endtask

  task automatic rTypeChainTest();
    prog.delete();
    prog.push_back(iEnc(addi, 1, 0, 5));
    prog.push_back(iEnc(addi, 2, 0, 3));
    prog.push_back(rEnc(functAdd, 3, 1, 2));
    prog.push_back(rEnc(functSub, 4, 3, 1));
    prog.push_back(rEnc(functAnd, 5, 4, 3));
    prog.push_back(rEnc(functOr, 6, 5, 4));
    prog.push_back(rEnc(functSlt, 7, 4, 3));
    prog.push_back(rEnc(functSub, 9, 2, 1));
    prog.push_back(rEnc(functSlt, 10, 9, 2));
    prog.push_back(rEnc(functAdd, 11, 10, 10));
    addSelfJump();
    runProgram("R-type chains");
  endtask

  task automatic memoryTest();
    prog.delete();
    prog.push_back(iEnc(addi, 1, 0, 32'h200));
    prog.push_back(iEnc(addi, 2, 0, 77));
    prog.push_back(iEnc(sw, 2, 1, 0));
    prog.push_back(iEnc(lw, 3, 1, 0));
    // Load-use on r3
    prog.push_back(rEnc(functAdd, 4, 3, 3));
    prog.push_back(iEnc(addi, 5, 0, -9));
    prog.push_back(iEnc(sw, 5, 1, 8));
    prog.push_back(iEnc(lw, 6, 1, 4));
    prog.push_back(iEnc(lw, 7, 1, 8));
    prog.push_back(rEnc(functSub, 8, 7, 6));
    prog.push_back(iEnc(sw, 8, 1, 12));
    prog.push_back(iEnc(lw, 9, 1, 12));
    prog.push_back(rEnc(functOr, 10, 9, 4));
    addSelfJump();
    runProgram("load and store");
  endtask

  task automatic controlFlowTest();
    prog.delete();
    prog.push_back(iEnc(addi, 1, 0, 4));
    prog.push_back(iEnc(addi, 2, 0, 4));
    prog.push_back(iEnc(beq, 2, 1, 1));
    prog.push_back(iEnc(addi, 3, 0, 99));
    prog.push_back(iEnc(bne, 2, 1, 1));
    prog.push_back(iEnc(addi, 4, 0, 11));
    prog.push_back(iEnc(addi, 5, 0, 5));
    // Branch on a value still in execute
    prog.push_back(iEnc(bne, 1, 5, 1));
    prog.push_back(iEnc(addi, 6, 0, 99));
    prog.push_back(iEnc(beq, 1, 5, 1));
    prog.push_back(iEnc(addi, 7, 0, 12));
    prog.push_back(jEnc(13));
    prog.push_back(iEnc(addi, 8, 0, 99));
    prog.push_back(iEnc(addi, 9, 0, 32'h200));
    prog.push_back(iEnc(sw, 7, 9, 0));
    prog.push_back(iEnc(lw, 10, 9, 0));
    prog.push_back(iEnc(beq, 7, 10, 1));
    prog.push_back(iEnc(addi, 11, 0, 99));
    prog.push_back(rEnc(functAdd, 12, 10, 4));
    addSelfJump();
    runProgram("control flow");
  endtask

  task automatic immediateZeroTest();
    prog.delete();
    prog.push_back(iEnc(addi, 1, 0, -1));
    prog.push_back(iEnc(addi, 2, 1, -32768));
    prog.push_back(iEnc(addi, 0, 1, 5));
    prog.push_back(rEnc(functAdd, 0, 1, 2));
    prog.push_back(rEnc(functAdd, 3, 0, 1));
    prog.push_back(iEnc(addi, 4, 0, 32767));
    prog.push_back(rEnc(functSub, 5, 0, 4));
    prog.push_back(rEnc(functSlt, 6, 5, 0));
    prog.push_back(rEnc(functOr, 7, 0, 0));
    addSelfJump();
    runProgram("immediates and register zero");
  endtask

  task automatic randomProgramTest();
    logic [31:0] rnd;
    int          dest;
    int          src1;
    int          src2;
    prog.delete();
    for (int k = 1; k <= 4; k++) begin
      rnd = $random(seed);
      prog.push_back(iEnc(addi, k, 0, int'(rnd[15:0])));
    end
    // Only r0 to r4 so forwarding hits often
    for (int i = 0; i < 40; i++) begin
      rnd = $random(seed);
      dest = int'(rnd[10:8] % 3'd5);
      src1 = int'(rnd[13:11] % 3'd5);
      src2 = int'(rnd[16:14] % 3'd5);
      case (rnd[2:0] % 3'd6)
        3'd0:    prog.push_back(rEnc(functAdd, dest, src1, src2));
        3'd1:    prog.push_back(rEnc(functSub, dest, src1, src2));
        3'd2:    prog.push_back(rEnc(functAnd, dest, src1, src2));
        3'd3:    prog.push_back(rEnc(functOr, dest, src1, src2));
        3'd4:    prog.push_back(rEnc(functSlt, dest, src1, src2));
        default: prog.push_back(iEnc(addi, dest, src1, int'(rnd[31:16])));
      endcase
    end
    addSelfJump();
    runProgram("random program");
  endtask

  initial begin
    rstN = 1'b0;
    progWe = 1'b0;
    progAddr = '0;
    progData = '0;
    rTypeChainTest();
    memoryTest();
    controlFlowTest();
    immediateZeroTest();
    randomProgramTest();
    $display("Checks: %0d, value errors: %0d, other errors: %0d",
             checkCount, valueErrors, otherErrors);
    if (valueErrors == 0 && otherErrors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// ==== build.f ====
src/isaPkg.sv
src/pipePkg.sv
src/fetchStage.sv
src/decodeStage.sv
src/hazardUnit.sv
src/executeStage.sv
src/unifiedMemory.sv
src/memWriteback.sv
src/cpu.sv
testbench/cpu_props.sv
testbench/cpuTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module cpuTb -f build.f -o cpuTbSim
./obj_dir/cpuTbSim | tee sim.log

if grep -qx "sim passed" sim.log; then
  echo "Result: PASS"
else
  echo "Result: FAIL"
  exit 1
fi
